// File: common/forth_consts.svh
/* widths, depths and opcode field size of the byte-code Forth engine
   FORTH_SP_W must hold the value FORTH_SS_DEPTH, so it counts 0 to depth */
`ifndef FORTH_CONSTS_SVH
`define FORTH_CONSTS_SVH

// data path
`define FORTH_DSZ       32      // one data word

// code space, 1 KiB of byte code
`define FORTH_ASZ       10

// data stack below tos
`define FORTH_SS_DEPTH  16      // cells, tos not counted
`define FORTH_SP_W      5       // pointer, 0 .. depth

// instruction byte, 1 flag bit + opcode or short literal
`define FORTH_OP_W      7

`endif

// File: common/forth_pkg.sv
/* shared types of the Forth engine; opcode values are fixed, byte code depends on them
   instruction bit 7 set means short literal, clear means opcode */
`default_nettype none

`include "forth_consts.svh"

package forth_pkg;

    typedef logic [`FORTH_DSZ-1:0] word_t;    // data word
    typedef logic [`FORTH_ASZ-1:0] addr_t;    // code byte address

    // byte code opcodes, eForth naming
    typedef enum logic [`FORTH_OP_W-1:0] {
        _NOP   = 7'h00,
        _DOLIT = 7'h01,     // 4 bytes follow, little endian
        _BRAN  = 7'h02,     // signed offset byte follows
        _0BRAN = 7'h03,     // pops, branches on zero
        _DUP   = 7'h04,
        _DROP  = 7'h05,
        _OVER  = 7'h06,
        _SWAP  = 7'h07,
        _ADD   = 7'h08,
        _SUB   = 7'h09,
        _MUL   = 7'h0a,
        _AND   = 7'h0b,
        _OR    = 7'h0c,
        _XOR   = 7'h0d,
        _ABS   = 7'h0e,
        _NEG   = 7'h0f,
        _ZEQ   = 7'h10,
        _ZLT   = 7'h11,
        _EQ    = 7'h12,
        _LT    = 7'h13,
        _EMIT  = 7'h14,     // pops, low byte goes out
        _BYE   = 7'h15
    } opcode_e;

    // same code byte, two readings, the flag bit decides
    typedef struct packed {
        logic    lit;       // 0 here
        opcode_e op;
    } op_form_t;

    typedef struct packed {
        logic                   lit;    // 1 here
        logic [`FORTH_OP_W-1:0] val;    // pushed zero extended
    } lit_form_t;

    typedef union packed {
        op_form_t  op_form;
        lit_form_t lit_form;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR,
        ALU_ABS, ALU_NEG, ALU_ZEQ, ALU_ZLT, ALU_EQ, ALU_LT
    } alu_op_e;

    // push+pop together means replace top cell
    typedef struct packed {
        logic  clear;       // empties stack, clears fault flags
        logic  push;
        logic  pop;
        word_t wdata;
    } stack_cmd_t;

    typedef struct packed {
        word_t                  s0;     // second item, zero when empty
        logic [`FORTH_SP_W-1:0] sp;     // cells in use
        logic                   overflow;
        logic                   underflow;
    } stack_view_t;

    typedef struct packed {
        logic  done;        // one cycle strobe
        logic  fault;       // held until next start
        word_t tos;         // held until next start
    } core_status_t;

endpackage

`default_nettype wire

// File: eforth/code_mem.sv
/* byte code memory, one write port for the host loader
   read data is registered, valid the cycle after raddr; no reset of contents */
`timescale 1ns/100ps
`default_nettype none

`include "forth_consts.svh"

module code_mem (
    input  logic             clk,
    input  logic             we,        // host load strobe
    input  forth_pkg::addr_t waddr,
    input  logic [7:0]       wdata,
    input  forth_pkg::addr_t raddr,     // from ip
    output logic [7:0]       rdata
);

    localparam int BYTES = 1 << `FORTH_ASZ;

    logic [7:0] mem [BYTES];

    // load port
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // fetch port, read before write on same address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: eforth/data_stack.sv
/* register array stack below tos, FORTH_SS_DEPTH cells
   a faulting command is dropped; fault flags stay set until clear or reset */
`timescale 1ns/100ps
`default_nettype none

`include "forth_consts.svh"

module data_stack (
    input  logic                   clk,
    input  logic                   rst,
    input  forth_pkg::stack_cmd_t  cmd,
    output forth_pkg::stack_view_t view
);

    localparam int IDX_W = $clog2(`FORTH_SS_DEPTH);

    forth_pkg::word_t       cells [`FORTH_SS_DEPTH];
    forth_pkg::word_t       s0;
    logic [`FORTH_SP_W-1:0] sp_q;
    logic [`FORTH_SP_W-1:0] top;        // index of s0
    logic                   ovf_q, unf_q;
    logic                   empty, full;
    logic                   do_push, do_pop, do_repl;

    assign top   = sp_q - 1'b1;
    assign empty = (sp_q == '0);
    assign full  = (sp_q == `FORTH_SP_W'(`FORTH_SS_DEPTH));

    // legal commands only
    assign do_push = cmd.push & ~cmd.pop & ~full & ~cmd.clear;
    assign do_pop  = cmd.pop & ~cmd.push & ~empty & ~cmd.clear;
    assign do_repl = cmd.push & cmd.pop & ~empty & ~cmd.clear;     // SWAP

    always_ff @(posedge clk) begin
        if (rst || cmd.clear) begin
            sp_q  <= '0;
            ovf_q <= 1'b0;
            unf_q <= 1'b0;
        end else begin
            if (do_push)
                sp_q <= sp_q + 1'b1;
            else if (do_pop)
                sp_q <= top;
            if (cmd.push && !cmd.pop && full)
                ovf_q <= 1'b1;
            if (cmd.pop && empty)       // pop or replace on nothing
                unf_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            cells[sp_q[IDX_W-1:0]] <= cmd.wdata;
        else if (do_repl)
            cells[top[IDX_W-1:0]] <= cmd.wdata;
    end

    assign s0 = empty ? '0 : cells[top[IDX_W-1:0]];
    assign view = '{s0: s0, sp: sp_q, overflow: ovf_q, underflow: unf_q};

endmodule

`default_nettype wire

// File: eforth/eforth_alu.sv
/* combinational ALU, binary ops give b op a with a = tos, b = s0
   results wrap to the word width; true is all ones */
`timescale 1ns/100ps
`default_nettype none

module eforth_alu (
    input  forth_pkg::alu_op_e op,
    input  forth_pkg::word_t   a,       // tos
    input  forth_pkg::word_t   b,       // s0
    output forth_pkg::word_t   y
);

    forth_pkg::word_t neg_a;

    assign neg_a = -a;

    always_comb begin
        case (op)
            forth_pkg::ALU_ADD: y = b + a;
            forth_pkg::ALU_SUB: y = b - a;      // second minus top
            forth_pkg::ALU_MUL: y = b * a;      // low word kept
            forth_pkg::ALU_AND: y = b & a;
            forth_pkg::ALU_OR:  y = b | a;
            forth_pkg::ALU_XOR: y = b ^ a;
            // unary, b unused
            forth_pkg::ALU_ABS: y = a[$bits(a)-1] ? neg_a : a;  // min int stays
            forth_pkg::ALU_NEG: y = neg_a;
            // compares, Forth true is all ones
            forth_pkg::ALU_ZEQ: y = (a == '0) ? '1 : '0;
            forth_pkg::ALU_ZLT: y = a[$bits(a)-1] ? '1 : '0;
            forth_pkg::ALU_EQ:  y = (b == a) ? '1 : '0;
            forth_pkg::ALU_LT:  y = ($signed(b) < $signed(a)) ? '1 : '0;
            default:            y = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: eforth/eforth_ctrl.sv
/* inner interpreter FSM, one fetch and one execute cycle per instruction
   stack faults end the run with done and fault set, tos keeps its last good value
   OVER on an empty stack reads s0 as zero; unknown opcodes act as NOP */
`timescale 1ns/100ps
`default_nettype none

`include "forth_consts.svh"

module eforth_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  forth_pkg::addr_t        pfa,
    output forth_pkg::addr_t        mem_raddr,
    input  logic [7:0]              mem_rdata,
    output forth_pkg::stack_cmd_t   stk_cmd,
    input  forth_pkg::stack_view_t  stk,
    output forth_pkg::alu_op_e      alu_op,
    input  forth_pkg::word_t        alu_y,
    output forth_pkg::word_t        tos,
    output logic                    busy,
    output forth_pkg::core_status_t status,
    output logic                    emit_valid,
    output logic [7:0]              emit_char
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_EXEC, ST_LIT_BYTE, ST_BRANCH_OFF, ST_FINISH
    } state_e;

    state_e                 st_q, st_n;
    forth_pkg::addr_t       ip_q, ip_n;         // instruction pointer
    forth_pkg::word_t       tos_q, tos_n;       // top of stack register
    logic [`FORTH_DSZ-9:0]  lit_q, lit_n;       // DOLIT bytes 0..2
    logic [1:0]             cnt_q, cnt_n;       // DOLIT byte count
    logic                   br_take_q, br_take_n;
    logic                   fault_q, fault_n;
    logic                   emit_n;
    logic                   stk_fault;          // flag from stack, sticky
    logic                   bad_cmd;            // this cycle's command would fault
    forth_pkg::instr_u      ins;

    // opcode to ALU function, only looked at in exec
    function automatic forth_pkg::alu_op_e alu_sel(input forth_pkg::opcode_e op);
        case (op)
            forth_pkg::_SUB: return forth_pkg::ALU_SUB;
            forth_pkg::_MUL: return forth_pkg::ALU_MUL;
            forth_pkg::_AND: return forth_pkg::ALU_AND;
            forth_pkg::_OR:  return forth_pkg::ALU_OR;
            forth_pkg::_XOR: return forth_pkg::ALU_XOR;
            forth_pkg::_ABS: return forth_pkg::ALU_ABS;
            forth_pkg::_NEG: return forth_pkg::ALU_NEG;
            forth_pkg::_ZEQ: return forth_pkg::ALU_ZEQ;
            forth_pkg::_ZLT: return forth_pkg::ALU_ZLT;
            forth_pkg::_EQ:  return forth_pkg::ALU_EQ;
            forth_pkg::_LT:  return forth_pkg::ALU_LT;
            default:         return forth_pkg::ALU_ADD;
        endcase
    endfunction

    assign mem_raddr = ip_q;            // rdata lands one cycle later
    assign tos       = tos_q;
    assign busy      = (st_q != ST_IDLE);
    assign status    = '{done: (st_q == ST_FINISH), fault: fault_q, tos: tos_q};

    always_comb begin
        ins       = mem_rdata;
        stk_fault = stk.overflow | stk.underflow;
        alu_op    = alu_sel(ins.op_form.op);
        st_n      = st_q;
        ip_n      = ip_q;
        tos_n     = tos_q;
        lit_n     = lit_q;
        cnt_n     = cnt_q;
        br_take_n = br_take_q;
        fault_n   = fault_q;
        emit_n    = 1'b0;
        stk_cmd   = '{clear: 1'b0, push: 1'b0, pop: 1'b0, wdata: tos_q};

        case (st_q)
            ST_IDLE: begin
                if (start) begin
                    st_n          = ST_FETCH;
                    ip_n          = pfa;
                    tos_n         = '0;
                    fault_n       = 1'b0;
                    stk_cmd.clear = 1'b1;   // fresh stack per run
                end
            end
            ST_FETCH: begin
                st_n = ST_EXEC;
                ip_n = ip_q + 1'b1;
            end
            ST_EXEC: begin
                st_n = ST_FETCH;
                if (ins.lit_form.lit) begin         // short literal
                    stk_cmd.push = 1'b1;
                    tos_n = {{(`FORTH_DSZ-`FORTH_OP_W){1'b0}}, ins.lit_form.val};
                end else begin
                    case (ins.op_form.op)
                        forth_pkg::_DOLIT: begin
                            st_n  = ST_LIT_BYTE;
                            cnt_n = 2'd0;
                            ip_n  = ip_q + 1'b1;    // byte 0 already on the way
                        end
                        forth_pkg::_BRAN: begin
                            st_n      = ST_BRANCH_OFF;
                            br_take_n = 1'b1;
                            ip_n      = ip_q + 1'b1;
                        end
                        forth_pkg::_0BRAN: begin
                            st_n        = ST_BRANCH_OFF;
                            br_take_n   = (tos_q == '0);
                            stk_cmd.pop = 1'b1;
                            tos_n       = stk.s0;
                            ip_n        = ip_q + 1'b1;
                        end
                        forth_pkg::_DUP:  stk_cmd.push = 1'b1;
                        forth_pkg::_DROP: begin
                            stk_cmd.pop = 1'b1;
                            tos_n       = stk.s0;
                        end
                        forth_pkg::_OVER: begin
                            stk_cmd.push = 1'b1;
                            tos_n        = stk.s0;
                        end
                        forth_pkg::_SWAP: begin             // replace s0 with old tos
                            stk_cmd.push = 1'b1;
                            stk_cmd.pop  = 1'b1;
                            tos_n        = stk.s0;
                        end
                        forth_pkg::_ADD, forth_pkg::_SUB, forth_pkg::_MUL,
                        forth_pkg::_AND, forth_pkg::_OR, forth_pkg::_XOR,
                        forth_pkg::_EQ, forth_pkg::_LT: begin
                            stk_cmd.pop = 1'b1;             // s0 consumed
                            tos_n       = alu_y;
                        end
                        forth_pkg::_ABS, forth_pkg::_NEG,
                        forth_pkg::_ZEQ, forth_pkg::_ZLT: tos_n = alu_y;
                        forth_pkg::_EMIT: begin
                            emit_n      = 1'b1;
                            stk_cmd.pop = 1'b1;
                            tos_n       = stk.s0;
                        end
                        forth_pkg::_BYE: st_n = ST_FINISH;
                        default: ;                          // NOP
                    endcase
                end
            end
            ST_LIT_BYTE: begin
                if (cnt_q == 2'd3) begin                    // last byte, push
                    st_n         = ST_FETCH;
                    stk_cmd.push = 1'b1;
                    tos_n        = {mem_rdata, lit_q};
                end else begin
                    lit_n = {mem_rdata, lit_q[`FORTH_DSZ-9:8]};
                    cnt_n = cnt_q + 1'b1;
                    ip_n  = ip_q + 1'b1;
                end
            end
            ST_BRANCH_OFF: begin
                st_n = ST_FETCH;
                if (br_take_q)      // offset counts from byte after it
                    ip_n = ip_q + {{(`FORTH_ASZ-8){mem_rdata[7]}}, mem_rdata};
            end
            default: st_n = ST_IDLE;                        // finish
        endcase

        // stack refused a command last edge, wrap up
        if (stk_fault && st_q != ST_IDLE && st_q != ST_FINISH) begin
            st_n    = ST_FINISH;
            fault_n = 1'b1;
        end

        // faulting command leaves tos and output alone
        bad_cmd = (stk_cmd.pop && stk.sp == '0) ||
                  (stk_cmd.push && !stk_cmd.pop &&
                   stk.sp == `FORTH_SP_W'(`FORTH_SS_DEPTH));
        if (bad_cmd) begin
            tos_n  = tos_q;
            emit_n = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_q       <= ST_IDLE;
            ip_q       <= '0;
            tos_q      <= '0;
            cnt_q      <= 2'd0;
            br_take_q  <= 1'b0;
            fault_q    <= 1'b0;
            emit_valid <= 1'b0;
        end else begin
            st_q       <= st_n;
            ip_q       <= ip_n;
            tos_q      <= tos_n;
            cnt_q      <= cnt_n;
            br_take_q  <= br_take_n;
            fault_q    <= fault_n;
            emit_valid <= emit_n;   // one cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        lit_q <= lit_n;
        if (emit_n)
            emit_char <= tos_q[7:0];
    end

endmodule

`default_nettype wire

// File: src/forth_core.sv
/* byte-code Forth engine top, control FSM with stack, ALU and code memory
   host loads are dropped while busy; start while busy is ignored */
`timescale 1ns/100ps
`default_nettype none

module forth_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_we,
    input  forth_pkg::addr_t        load_addr,
    input  logic [7:0]              load_data,
    input  logic                    start,
    input  forth_pkg::addr_t        pfa,
    output logic                    busy,
    output forth_pkg::core_status_t status,
    output logic                    emit_valid,
    output logic [7:0]              emit_char
);

    forth_pkg::addr_t       mem_raddr;
    logic [7:0]             mem_rdata;
    logic                   mem_we;         // host load, idle only
    forth_pkg::stack_cmd_t  stk_cmd;
    forth_pkg::stack_view_t stk_view;
    forth_pkg::alu_op_e     alu_op;
    forth_pkg::word_t       alu_y;
    forth_pkg::word_t       tos;

    assign mem_we = load_we & ~busy;

    eforth_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pfa        (pfa),
        .mem_raddr  (mem_raddr),
        .mem_rdata  (mem_rdata),
        .stk_cmd    (stk_cmd),
        .stk        (stk_view),
        .alu_op     (alu_op),
        .alu_y      (alu_y),
        .tos        (tos),
        .busy       (busy),
        .status     (status),
        .emit_valid (emit_valid),
        .emit_char  (emit_char)
    );

    data_stack u_stack (
        .clk  (clk),
        .rst  (rst),
        .cmd  (stk_cmd),
        .view (stk_view)
    );

    // a = tos, b = second item
    eforth_alu u_alu (
        .op (alu_op),
        .a  (tos),
        .b  (stk_view.s0),
        .y  (alu_y)
    );

    code_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verif/tb_forth_core.sv
/* testbench for forth_core, every program is loaded at address 0 and started with pfa 0
   each row checks the final status and the emitted characters, waits give up after 2000 cycles */
`timescale 1ns/100ps
`default_nettype none

module tb_forth_core;

    localparam int TIMEOUT = 2000;          // cycles per wait

    logic                    clk;
    logic                    rst;
    logic                    load_we;
    forth_pkg::addr_t        load_addr;
    logic [7:0]              load_data;
    logic                    start;
    forth_pkg::addr_t        pfa;
    logic                    busy;
    forth_pkg::core_status_t status;
    logic                    emit_valid;
    logic [7:0]              emit_char;

    // stimulus table, programs packed back to back in prog_bytes
    string            row_name[$];
    int               row_first[$];
    int               row_len[$];
    forth_pkg::word_t row_tos[$];
    logic             row_fault[$];
    string            row_emit[$];
    logic [7:0]       prog_bytes[$];
    logic [7:0]       pend[$];              // program under construction

    logic [7:0]              emitted[$];    // chars seen in current run
    forth_pkg::core_status_t last_status;   // status at the done strobe
    int                      errors;
    int                      loop_row;      // countdown row, reused for busy test
    logic                    timed_out;     // a run never finished, rest skipped
    logic [31:0]             rng;

    forth_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .start      (start),
        .pfa        (pfa),
        .busy       (busy),
        .status     (status),
        .emit_valid (emit_valid),
        .emit_char  (emit_char)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic rand_word(output forth_pkg::word_t v);
        rng = xorshift(rng);
        v   = rng;
    endtask

    function automatic logic [7:0] opc(input forth_pkg::opcode_e o);
        return {1'b0, o};                   // flag bit clear, opcode below
    endfunction

    // Forth rules, b is second item and a is top
    function automatic forth_pkg::word_t alu_expect(input forth_pkg::opcode_e o,
                                                    input forth_pkg::word_t b,
                                                    input forth_pkg::word_t a);
        case (o)
            forth_pkg::_ADD: return b + a;
            forth_pkg::_SUB: return b - a;
            forth_pkg::_MUL: return b * a;                  // low 32 bits
            forth_pkg::_AND: return b & a;
            forth_pkg::_OR:  return b | a;
            forth_pkg::_XOR: return b ^ a;
            forth_pkg::_NEG: return 32'd0 - a;
            forth_pkg::_ABS: return a[31] ? 32'd0 - a : a;  // min int wraps to itself
            default:         return 32'd0;
        endcase
    endfunction

    task automatic put(input logic [7:0] b);
        pend.push_back(b);
    endtask

    task automatic put_lit(input logic [6:0] v);
        pend.push_back({1'b1, v});          // short literal
    endtask

    task automatic put_dolit(input forth_pkg::word_t v);
        pend.push_back(opc(forth_pkg::_DOLIT));
        for (int i = 0; i < 4; i++)
            pend.push_back(v[8*i +: 8]);    // little endian
    endtask

    task automatic add_row(input string name, input forth_pkg::word_t tos,
                           input logic fault, input string em);
        if (pend.size() > 24) begin
            $display("row %s has a program longer than 24 bytes", name);
            errors++;
        end
        row_name.push_back(name);
        row_first.push_back(prog_bytes.size());
        row_len.push_back(pend.size());
        row_tos.push_back(tos);
        row_fault.push_back(fault);
        row_emit.push_back(em);
        foreach (pend[i])
            prog_bytes.push_back(pend[i]);
        pend.delete();
    endtask

    task automatic check_word(input string name, input forth_pkg::word_t exp,
                              input forth_pkg::word_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input forth_pkg::core_status_t exp,
                                input forth_pkg::core_status_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected done/fault/tos %0b/%0b/%h actual %0b/%0b/%h",
                     name, exp.done, exp.fault, exp.tos, act.done, act.fault, act.tos);
            errors++;
        end
    endtask

    task automatic check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_emits(input string name, input string s);
        if (emitted.size() != s.len()) begin
            $display("%s emitted %0d characters but %0d were expected",
                     name, emitted.size(), s.len());
            errors++;
        end
        for (int i = 0; i < s.len() && i < emitted.size(); i++)
            check_char($sformatf("%s char %0d", name, i), s[i], emitted[i]);
    endtask

    task automatic load_program(input int first, input int len);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = forth_pkg::addr_t'(i);
            load_data = prog_bytes[first + i];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic pulse_start(input forth_pkg::addr_t a);
        @(negedge clk);
        start = 1'b1;
        pfa   = a;
        @(negedge clk);
        start = 1'b0;
    endtask

    // collects emits on the way, keeps status from the done cycle
    task automatic wait_done(input string name);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            if (emit_valid)
                emitted.push_back(emit_char);
            if (status.done) begin
                seen        = 1'b1;
                last_status = status;
            end
            n++;
        end
        if (!seen) begin
            $display("timeout: %s gave no done within %0d cycles", name, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_idle(input string name);
        @(negedge clk);
        if (busy) begin
            $display("%s: busy still high one cycle after done", name);
            errors++;
        end
    endtask

    task automatic run_row(input int i);
        forth_pkg::core_status_t exp;
        emitted.delete();
        load_program(row_first[i], row_len[i]);
        pulse_start('0);
        wait_done(row_name[i]);
        if (!timed_out) begin
            exp = '{done: 1'b1, fault: row_fault[i], tos: row_tos[i]};
            check_status(row_name[i], exp, last_status);
            check_emits(row_name[i], row_emit[i]);
            check_idle(row_name[i]);
        end
    endtask

    // second start lands mid run and must change nothing
    task automatic busy_protocol(input int i);
        int extra;
        extra = 0;
        emitted.delete();
        load_program(row_first[i], row_len[i]);
        pulse_start('0);
        if (!busy) begin
            $display("busy test: busy low right after start");
            errors++;
        end
        start = 1'b1;
        pfa   = forth_pkg::addr_t'(5);      // would skip the loop setup
        @(negedge clk);
        start = 1'b0;
        wait_done("busy test");
        if (!timed_out) begin
            check_word("busy test tos", row_tos[i], last_status.tos);
            check_emits("busy test", row_emit[i]);
            check_idle("busy test");
            for (int c = 0; c < 50; c++) begin
                @(negedge clk);
                if (status.done)
                    extra++;
            end
            if (extra != 0) begin
                $display("busy test: %0d extra done strobes after the ignored start", extra);
                errors++;
            end
        end
    endtask

    task automatic build_rows();
        forth_pkg::opcode_e ops[8];
        forth_pkg::word_t   a;
        forth_pkg::word_t   b;
        ops = '{forth_pkg::_ADD, forth_pkg::_SUB, forth_pkg::_MUL, forth_pkg::_AND,
                forth_pkg::_OR, forth_pkg::_XOR, forth_pkg::_NEG, forth_pkg::_ABS};
        // literals
        put_lit(7'd0);
        put(opc(forth_pkg::_BYE));
        add_row("lit 0", 32'd0, 1'b0, "");
        put_lit(7'd127);
        put(opc(forth_pkg::_BYE));
        add_row("lit 127", 32'd127, 1'b0, "");
        put_dolit(32'h1234_5678);
        put(opc(forth_pkg::_BYE));
        add_row("dolit 12345678", 32'h1234_5678, 1'b0, "");
        put_dolit(32'hdead_beef);
        put(opc(forth_pkg::_BYE));
        add_row("dolit deadbeef", 32'hdead_beef, 1'b0, "");
        // ALU, two random operand pairs per op
        for (int r = 0; r < 2; r++) begin
            foreach (ops[k]) begin
                rand_word(b);
                rand_word(a);
                put_dolit(b);
                put_dolit(a);
                put(opc(ops[k]));
                put(opc(forth_pkg::_BYE));
                add_row($sformatf("alu %s #%0d", ops[k].name(), r), alu_expect(ops[k], b, a),
                        1'b0, "");
            end
        end
        put_dolit(32'h8000_0000);
        put(opc(forth_pkg::_ABS));
        put(opc(forth_pkg::_BYE));
        add_row("abs min int", 32'h8000_0000, 1'b0, "");
        // compares, true is all ones
        rand_word(a);
        put_dolit(a);
        put_dolit(a);
        put(opc(forth_pkg::_EQ));
        put(opc(forth_pkg::_BYE));
        add_row("eq same", 32'hffff_ffff, 1'b0, "");
        put_dolit(a);
        put_dolit(a ^ 32'h0000_0100);
        put(opc(forth_pkg::_EQ));
        put(opc(forth_pkg::_BYE));
        add_row("eq differ", 32'd0, 1'b0, "");
        put_dolit(32'hffff_fffb);           // -5 < 3
        put_lit(7'd3);
        put(opc(forth_pkg::_LT));
        put(opc(forth_pkg::_BYE));
        add_row("lt neg below pos", 32'hffff_ffff, 1'b0, "");
        put_lit(7'd3);
        put_dolit(32'hffff_fffb);
        put(opc(forth_pkg::_LT));
        put(opc(forth_pkg::_BYE));
        add_row("lt pos below neg", 32'd0, 1'b0, "");
        put_lit(7'd0);
        put(opc(forth_pkg::_ZEQ));
        put(opc(forth_pkg::_BYE));
        add_row("zeq zero", 32'hffff_ffff, 1'b0, "");
        put_lit(7'd9);
        put(opc(forth_pkg::_ZEQ));
        put(opc(forth_pkg::_BYE));
        add_row("zeq nine", 32'd0, 1'b0, "");
        put_dolit(32'h8000_0001);
        put(opc(forth_pkg::_ZLT));
        put(opc(forth_pkg::_BYE));
        add_row("zlt negative", 32'hffff_ffff, 1'b0, "");
        put_lit(7'd1);
        put(opc(forth_pkg::_ZLT));
        put(opc(forth_pkg::_BYE));
        add_row("zlt positive", 32'd0, 1'b0, "");
        // stack ops
        put_lit(7'd3);
        put(opc(forth_pkg::_DUP));
        put(opc(forth_pkg::_ADD));
        put(opc(forth_pkg::_BYE));
        add_row("dup add", 32'd6, 1'b0, "");
        put_lit(7'd3);
        put_lit(7'd4);
        put(opc(forth_pkg::_DROP));
        put(opc(forth_pkg::_BYE));
        add_row("drop", 32'd3, 1'b0, "");
        put_lit(7'd3);
        put_lit(7'd4);
        put(opc(forth_pkg::_OVER));
        put(opc(forth_pkg::_SUB));          // 4 - 3
        put(opc(forth_pkg::_BYE));
        add_row("over sub", 32'd1, 1'b0, "");
        put_lit(7'd10);
        put_lit(7'd3);
        put(opc(forth_pkg::_SWAP));
        put(opc(forth_pkg::_SUB));          // 3 - 10
        put(opc(forth_pkg::_BYE));
        add_row("swap sub", 32'hffff_fff9, 1'b0, "");
        // countdown from 3, emits digit per pass, exits through 0BRAN
        loop_row = row_name.size();
        put_lit(7'd3);
        put(opc(forth_pkg::_DUP));          // addr 1, loop head
        put(opc(forth_pkg::_0BRAN));
        put(8'h08);                         // to BYE at 12
        put(opc(forth_pkg::_DUP));
        put_lit(7'h30);                     // ascii 0
        put(opc(forth_pkg::_ADD));
        put(opc(forth_pkg::_EMIT));
        put_lit(7'd1);
        put(opc(forth_pkg::_SUB));
        put(opc(forth_pkg::_BRAN));
        put(8'hf5);                         // back to 1
        put(opc(forth_pkg::_BYE));
        add_row("countdown", 32'd0, 1'b0, "321");
        put_lit(7'd5);
        put(opc(forth_pkg::_BRAN));
        put(8'h01);                         // skips the next literal
        put_lit(7'd9);
        put(opc(forth_pkg::_BYE));
        add_row("bran forward", 32'd5, 1'b0, "");
        // faults, tos keeps the initial zero or the 16th push
        put(opc(forth_pkg::_DROP));
        put(opc(forth_pkg::_BYE));
        add_row("drop on empty", 32'd0, 1'b1, "");
        for (int k = 1; k <= 17; k++)
            put_lit(7'(k));
        put(opc(forth_pkg::_BYE));
        add_row("17 pushes", 32'd16, 1'b1, "");
    endtask

    initial begin
        rst       = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = 8'h00;
        start     = 1'b0;
        pfa       = '0;
        errors    = 0;
        loop_row  = 0;
        timed_out = 1'b0;
        rng       = 32'he6f5;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        if (busy || status.done || status.fault || emit_valid) begin
            $display("outputs not idle after reset");
            errors++;
        end
        check_word("reset tos", 32'd0, status.tos);
        build_rows();
        for (int i = 0; i < row_name.size() && !timed_out; i++)
            run_row(i);
        if (!timed_out)
            busy_protocol(loop_row);
        $display("errors: %0d in %0d rows and the busy test", errors, row_name.size());
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/forth_pkg.sv
eforth/code_mem.sv
eforth/data_stack.sv
eforth/eforth_alu.sv
eforth/eforth_ctrl.sv
src/forth_core.sv
verif/tb_forth_core.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module tb_forth_core -o tb_forth_core \
    && ./obj_dir/tb_forth_core | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
